/* hdl/lstm_state_pkg.sv */
package lstm_state_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // One element of i, f, a or s
  localparam int ELEM_W = 16;

  // Longest vector held in the state memory
  localparam int MAX_LEN = 16;
  localparam int IDX_W = 4;

  // Element value, also used for the modulus
  typedef logic [ELEM_W-1:0] elem_t;

  // Full width product before reduction
  typedef logic [2*ELEM_W-1:0] prod_t;

  // Element position inside a pass
  typedef logic [IDX_W-1:0] index_t;

  // Vector length, 1..MAX_LEN
  typedef logic [IDX_W:0] len_t;

  //////////////////////////////////////////////////
  // Pipeline beats
  //////////////////////////////////////////////////

  // Raw gate values from the input stream
  typedef struct packed {
    elem_t i;
    elem_t f;
    elem_t a;
  } gate_beat_t;

  // Gate values tagged with position and end of pass
  typedef struct packed {
    elem_t  i;
    elem_t  f;
    elem_t  a;
    index_t idx;
    logic   last;
  } seq_beat_t;

  // Both products, already reduced
  typedef struct packed {
    elem_t  fs;
    elem_t  ia;
    index_t idx;
    logic   last;
  } prod_beat_t;

  // New cell state for the output stream
  typedef struct packed {
    elem_t  s;
    index_t idx;
    logic   last;
  } state_beat_t;

endpackage

/* hdl/lstm_apb_pkg.sv */
package lstm_apb_pkg;

  //////////////////////////////////////////////////
  // Bus types
  //////////////////////////////////////////////////

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Master to slave
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // Slave to master
  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  localparam apb_addr_t REG_MODULUS    = 8'h00;
  localparam apb_addr_t REG_LENGTH     = 8'h04;
  // Write-only, any write zeroes the state memory
  localparam apb_addr_t REG_CLEAR      = 8'h08;
  // Read-only
  localparam apb_addr_t REG_STATUS     = 8'h0C;
  localparam apb_addr_t REG_PASS_COUNT = 8'h10;

  // Busy flag position in STATUS
  localparam int STATUS_BUSY_BIT = 0;

  // Values after reset
  localparam int unsigned MODULUS_RESET = 65521;
  localparam int unsigned LENGTH_RESET  = 8;

endpackage

/* hdl/lstm_state_regs.sv */
module lstm_state_regs (
  input  logic                    CLK,
  input  logic                    RST,
  input  lstm_apb_pkg::apb_req_t  apb_req,
  output lstm_apb_pkg::apb_rsp_t  apb_rsp,
  input  logic                    busy,
  input  logic                    pass_done,
  output lstm_state_pkg::elem_t   modulus,
  output lstm_state_pkg::len_t    length,
  output logic                    clear
);

  import lstm_state_pkg::*;
  import lstm_apb_pkg::*;

  //////////////////////////////////////////////////
  // Access decode
  //////////////////////////////////////////////////

  logic      access;
  logic      wr;
  logic      err;
  apb_data_t rdata;
  apb_data_t pass_count;

  // Zero-wait slave, so every access phase completes
  assign access = apb_req.psel && apb_req.penable;
  assign wr     = access && apb_req.pwrite;

  always_comb begin
    err   = 1'b0;
    rdata = '0;
    case (apb_req.paddr)
      REG_MODULUS: begin
        rdata = apb_data_t'(modulus);
        // 0 and 1 are no usable modulus
        if (apb_req.pwrite) begin
          err = busy || (apb_req.pwdata < 2) || (apb_req.pwdata > 32'h0000_FFFF);
        end
      end
      REG_LENGTH: begin
        rdata = apb_data_t'(length);
        if (apb_req.pwrite) begin
          err = busy || (apb_req.pwdata == '0) ||
                (apb_req.pwdata > apb_data_t'(MAX_LEN));
        end
      end
      REG_CLEAR: begin
        // Reads back as zero
        err = apb_req.pwrite && busy;
      end
      REG_STATUS: begin
        rdata[STATUS_BUSY_BIT] = busy;
        err = apb_req.pwrite;
      end
      REG_PASS_COUNT: begin
        rdata = pass_count;
        err = apb_req.pwrite;
      end
      default: begin
        err = 1'b1;
      end
    endcase
  end

  assign apb_rsp.prdata  = access ? rdata : '0;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && err;

  // Single cycle pulse, only ever while idle
  assign clear = wr && !err && (apb_req.paddr == REG_CLEAR);

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      modulus    <= elem_t'(MODULUS_RESET);
      length     <= len_t'(LENGTH_RESET);
      pass_count <= '0;
    end else begin
      if (wr && !err && (apb_req.paddr == REG_MODULUS)) begin
        modulus <= elem_t'(apb_req.pwdata);
      end
      if (wr && !err && (apb_req.paddr == REG_LENGTH)) begin
        length <= len_t'(apb_req.pwdata);
      end
      // Clear wins over a completing pass
      if (clear) begin
        pass_count <= '0;
      end else if (pass_done) begin
        pass_count <= pass_count + 1'b1;
      end
    end
  end

  // State memory must never be wiped under a running pass
  assert property (@(posedge CLK) disable iff (RST) !(clear && busy));

endmodule

/* hdl/lstm_gate_sequencer.sv */
module lstm_gate_sequencer (
  input  logic                        CLK,
  input  logic                        RST,
  input  lstm_state_pkg::gate_beat_t  in_beat,
  input  logic                        in_valid,
  output logic                        in_ready,
  input  lstm_state_pkg::len_t        length,
  input  logic                        advance,
  input  logic                        drained,
  output lstm_state_pkg::seq_beat_t   seq_beat,
  output logic                        seq_valid,
  output logic                        busy,
  output logic                        pass_done
);

  import lstm_state_pkg::*;

  //////////////////////////////////////////////////
  // Pass control
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE,
    STREAM,
    DRAIN
  } seq_state_t;

  seq_state_t state;
  index_t     idx;
  logic       accept;
  logic       last_in;

  // Input stalls with the pipe, and while the last beat drains
  assign in_ready = advance && (state != DRAIN);
  assign accept   = in_valid && in_ready;

  // Final element of the configured vector
  assign last_in = ({1'b0, idx} == (length - 1'b1));

  assign busy      = (state != IDLE);
  assign pass_done = (state == DRAIN) && drained;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      idx       <= '0;
      seq_valid <= 1'b0;
    end else begin
      // Stage register follows the shared advance
      if (advance) begin
        seq_valid <= accept;
      end
      case (state)
        IDLE, STREAM: begin
          if (accept) begin
            if (last_in) begin
              state <= DRAIN;
              idx   <= '0;
            end else begin
              state <= STREAM;
              idx   <= idx + 1'b1;
            end
          end
        end
        DRAIN: begin
          // Last beat now sits in the output register
          if (drained) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Beat register
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (accept) begin
      seq_beat <= '{i: in_beat.i, f: in_beat.f, a: in_beat.a, idx: idx, last: last_in};
    end
  end

  // Index stays inside the vector configured for this pass
  assert property (@(posedge CLK) disable iff (RST)
    seq_valid |-> ({1'b0, seq_beat.idx} < length));

endmodule

/* hdl/lstm_state_memory.sv */
module lstm_state_memory (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    clear,
  input  lstm_state_pkg::index_t  rd_idx,
  output lstm_state_pkg::elem_t   rd_state,
  input  logic                    wr_en,
  input  lstm_state_pkg::index_t  wr_idx,
  input  lstm_state_pkg::elem_t   wr_state
);

  import lstm_state_pkg::*;

  //////////////////////////////////////////////////
  // State array
  //////////////////////////////////////////////////

  // s(t-1;l) for every element l
  elem_t mem [MAX_LEN];

  // Combinational read for the product stage
  assign rd_state = mem[rd_idx];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      // s(t=0;l) = 0
      for (int l = 0; l < MAX_LEN; l++) begin
        mem[l] <= '0;
      end
    end else if (clear) begin
      // Whole vector in one cycle
      for (int l = 0; l < MAX_LEN; l++) begin
        mem[l] <= '0;
      end
    end else if (wr_en) begin
      // Write-back from the sum stage
      mem[wr_idx] <= wr_state;
    end
  end

endmodule

/* hdl/lstm_gate_product_stage.sv */
module lstm_gate_product_stage (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        advance,
  input  lstm_state_pkg::elem_t       modulus,
  input  lstm_state_pkg::seq_beat_t   seq_beat,
  input  logic                        seq_valid,
  output lstm_state_pkg::index_t      rd_idx,
  input  lstm_state_pkg::elem_t       rd_state,
  output lstm_state_pkg::prod_beat_t  prod_beat,
  output logic                        prod_valid
);

  import lstm_state_pkg::*;

  //////////////////////////////////////////////////
  // Modular products
  //////////////////////////////////////////////////

  // x*y mod m over the full 32 bit product
  function automatic elem_t mod_mul(elem_t x, elem_t y, elem_t m);
    prod_t p;
    p = prod_t'(x) * prod_t'(y);
    return elem_t'(p % prod_t'(m));
  endfunction

  elem_t fs;
  elem_t ia;

  // Previous state of the element in flight
  assign rd_idx = seq_beat.idx;

  // Forget path, f(t;l)*s(t-1;l)
  assign fs = mod_mul(seq_beat.f, rd_state, modulus);
  // Input path, i(t;l)*a(t;l)
  assign ia = mod_mul(seq_beat.i, seq_beat.a, modulus);

  //////////////////////////////////////////////////
  // Stage register
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prod_valid <= 1'b0;
    end else if (advance) begin
      prod_valid <= seq_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance && seq_valid) begin
      prod_beat <= '{fs: fs, ia: ia, idx: seq_beat.idx, last: seq_beat.last};
    end
  end

endmodule

/* hdl/lstm_state_sum_stage.sv */
module lstm_state_sum_stage (
  input  logic                         CLK,
  input  logic                         RST,
  input  lstm_state_pkg::elem_t        modulus,
  input  lstm_state_pkg::prod_beat_t   prod_beat,
  input  logic                         prod_valid,
  output lstm_state_pkg::state_beat_t  out_beat,
  output logic                         out_valid,
  input  logic                         out_ready,
  output logic                         advance,
  output logic                         wr_en,
  output lstm_state_pkg::index_t       wr_idx,
  output lstm_state_pkg::elem_t        wr_state,
  output logic                         drained
);

  import lstm_state_pkg::*;

  //////////////////////////////////////////////////
  // Modular sum
  //////////////////////////////////////////////////

  // One spare bit, both operands are below the modulus
  logic [ELEM_W:0] sum;
  elem_t           s_next;
  logic            load;

  assign sum    = {1'b0, prod_beat.fs} + {1'b0, prod_beat.ia};
  // At most one subtraction needed
  assign s_next = (sum >= {1'b0, modulus}) ? elem_t'(sum - {1'b0, modulus}) : sum[ELEM_W-1:0];

  // Whole pipe stalls only on a full, blocked output
  assign advance = !(out_valid && !out_ready);
  assign load    = advance && prod_valid;

  // Write-back on the same edge as the output load
  assign wr_en    = load;
  assign wr_idx   = prod_beat.idx;
  assign wr_state = s_next;
  assign drained  = load && prod_beat.last;

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= prod_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      out_beat <= '{s: s_next, idx: prod_beat.idx, last: prod_beat.last};
    end
  end

  // Reduced result on the stream
  assert property (@(posedge CLK) disable iff (RST)
    out_valid |-> (out_beat.s < modulus));

  // Beat held under back-pressure
  assert property (@(posedge CLK) disable iff (RST)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)));

endmodule

/* hdl/lstm_state_gate_top.sv */
module lstm_state_gate_top (
  input  logic                         CLK,
  input  logic                         RST,
  input  lstm_apb_pkg::apb_req_t       apb_req,
  output lstm_apb_pkg::apb_rsp_t       apb_rsp,
  input  lstm_state_pkg::gate_beat_t   in_beat,
  input  logic                         in_valid,
  output logic                         in_ready,
  output lstm_state_pkg::state_beat_t  out_beat,
  output logic                         out_valid,
  input  logic                         out_ready
);

  import lstm_state_pkg::*;

  //////////////////////////////////////////////////
  // Internal nets
  //////////////////////////////////////////////////

  // Configuration
  elem_t      modulus;
  len_t       length;
  logic       clear;
  logic       busy;
  logic       pass_done;

  // Pipeline
  logic       advance;
  seq_beat_t  seq_beat;
  logic       seq_valid;
  prod_beat_t prod_beat;
  logic       prod_valid;
  logic       drained;

  // State memory ports
  index_t     rd_idx;
  elem_t      rd_state;
  logic       wr_en;
  index_t     wr_idx;
  elem_t      wr_state;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  lstm_state_regs u_regs (
    .CLK(CLK), .RST(RST),
    .apb_req(apb_req), .apb_rsp(apb_rsp),
    .busy(busy), .pass_done(pass_done),
    .modulus(modulus), .length(length), .clear(clear)
  );

  //////////////////////////////////////////////////
  // Data path
  //////////////////////////////////////////////////

  lstm_gate_sequencer u_seq (
    .CLK(CLK), .RST(RST),
    .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
    .length(length), .advance(advance), .drained(drained),
    .seq_beat(seq_beat), .seq_valid(seq_valid),
    .busy(busy), .pass_done(pass_done)
  );

  lstm_state_memory u_mem (
    .CLK(CLK), .RST(RST), .clear(clear),
    .rd_idx(rd_idx), .rd_state(rd_state),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_state(wr_state)
  );

  lstm_gate_product_stage u_prod (
    .CLK(CLK), .RST(RST), .advance(advance), .modulus(modulus),
    .seq_beat(seq_beat), .seq_valid(seq_valid),
    .rd_idx(rd_idx), .rd_state(rd_state),
    .prod_beat(prod_beat), .prod_valid(prod_valid)
  );

  lstm_state_sum_stage u_sum (
    .CLK(CLK), .RST(RST), .modulus(modulus),
    .prod_beat(prod_beat), .prod_valid(prod_valid),
    .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
    .advance(advance),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_state(wr_state),
    .drained(drained)
  );

endmodule

/* dv/lstm_state_gate_tb.sv */
module lstm_state_gate_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import lstm_state_pkg::*;
  import lstm_apb_pkg::*;

  localparam int TIMEOUT = 200;
  localparam int unsigned SEED = 32'h4f0aacf4;

  // One entry of the stimulus table
  typedef struct packed {
    elem_t      modulus;
    len_t       length;
    logic       clear_before;
    logic [6:0] stall_pct;
    logic       busy_write;
  } pass_cfg_t;

  logic        CLK;
  logic        RST;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  gate_beat_t  in_beat;
  logic        in_valid;
  logic        in_ready;
  state_beat_t out_beat;
  logic        out_valid;
  logic        out_ready;

  // Table, gate values and reference state
  pass_cfg_t   passes [$];
  string       pass_names [$];
  gate_beat_t  gates [MAX_LEN];
  elem_t       model_s [MAX_LEN];
  elem_t       exp_s [MAX_LEN];
  int unsigned pass_count;
  elem_t       cur_mod;
  len_t        cur_len;

  lstm_state_gate_top i_dut (
    .CLK(CLK), .RST(RST),
    .apb_req(apb_req), .apb_rsp(apb_rsp),
    .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
    .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s expected %0d actual %0d", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout: %s within %0d cycles", what, TIMEOUT);
    $display("TESTBENCH FAILED");
    $fatal(1, "Timeout");
  endtask

  //////////////////////////////////////////////////
  // APB master
  //////////////////////////////////////////////////

  // Starts and ends 5 ns after a rising edge
  task automatic apb_transfer(input logic write, input apb_addr_t addr,
                              input apb_data_t wdata, output apb_data_t rdata,
                              output logic err);
    int cnt;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge CLK);
    #5;
    apb_req.penable = 1'b1;
    // Sample mid cycle
    #45;
    cnt = 0;
    while (!apb_rsp.pready) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        timeout_fail("APB pready never rose");
      end
      @(posedge CLK);
      #50;
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge CLK);
    #5;
    apb_req = '0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    apb_data_t unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  // Rejected write leaves the register unchanged
  task automatic expect_write_error(input string name, input apb_addr_t addr,
                                    input apb_data_t data, input apb_addr_t rb_addr,
                                    input logic [63:0] rb_exp);
    apb_data_t d;
    logic      err;
    apb_write(addr, data, err);
    check({name, " pslverr"}, 1, err);
    apb_read(rb_addr, d, err);
    check({name, " readback"}, rb_exp, d);
  endtask

  //////////////////////////////////////////////////
  // Streams and reference model
  //////////////////////////////////////////////////

  task automatic add_pass(input string name, input elem_t m, input len_t len,
                          input logic clr, input logic [6:0] stall, input logic busy_wr);
    passes.push_back('{modulus: m, length: len, clear_before: clr,
                       stall_pct: stall, busy_write: busy_wr});
    pass_names.push_back(name);
  endtask

  // s = (f*s_prev + i*a) mod m for every element
  task automatic prepare_gates(input elem_t m, input int len);
    longint unsigned fv, sv, iv, av;
    for (int k = 0; k < len; k++) begin
      gates[k].i = elem_t'($urandom);
      gates[k].f = elem_t'($urandom);
      gates[k].a = elem_t'($urandom);
      fv = gates[k].f;
      sv = model_s[k];
      iv = gates[k].i;
      av = gates[k].a;
      exp_s[k] = elem_t'((fv * sv + iv * av) % longint'(m));
    end
  endtask

  task automatic drive_inputs(input int len);
    int cnt;
    for (int k = 0; k < len; k++) begin
      in_beat  = gates[k];
      in_valid = 1'b1;
      cnt = 0;
      #45;
      while (!in_ready) begin
        cnt++;
        if (cnt > TIMEOUT) begin
          timeout_fail("in_ready stayed low");
        end
        @(posedge CLK);
        #50;
      end
      @(posedge CLK);
      #5;
    end
    in_valid = 1'b0;
  endtask

  task automatic collect_outputs(input string name, input int len, input int stall_pct,
                                 input elem_t m);
    int          n;
    int          idle;
    state_beat_t beat;
    n    = 0;
    idle = 0;
    while (n < len) begin
      // Random back-pressure
      out_ready = (($urandom % 100) >= stall_pct);
      #45;
      if (out_valid && out_ready) begin
        beat = out_beat;
        // Range first, so an unreduced state is reported as such
        check($sformatf("%s s below modulus[%0d]", name, n), 1, (beat.s < m));
        check($sformatf("%s s[%0d]", name, n), exp_s[n], beat.s);
        check($sformatf("%s idx[%0d]", name, n), n, beat.idx);
        check($sformatf("%s last[%0d]", name, n), (n == len - 1), beat.last);
        n++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          timeout_fail("no output beat transferred on out_valid");
        end
      end
      @(posedge CLK);
      #5;
    end
    out_ready = 1'b1;
  endtask

  task automatic write_length_while_busy(input string name);
    int        cnt;
    apb_data_t d;
    logic      err;
    cnt = 0;
    d   = '0;
    while (!d[STATUS_BUSY_BIT]) begin
      cnt++;
      if (cnt > TIMEOUT) begin
        timeout_fail("STATUS busy never rose");
      end
      apb_read(REG_STATUS, d, err);
    end
    expect_write_error({name, " length while busy"}, REG_LENGTH, 32'd3, REG_LENGTH, cur_len);
  endtask

  task automatic run_pass(input int p);
    pass_cfg_t cfg;
    string     name;
    apb_data_t d;
    logic      err;
    cfg  = passes[p];
    name = pass_names[p];
    apb_write(REG_MODULUS, apb_data_t'(cfg.modulus), err);
    check({name, " modulus pslverr"}, 0, err);
    cur_mod = cfg.modulus;
    apb_write(REG_LENGTH, apb_data_t'(cfg.length), err);
    check({name, " length pslverr"}, 0, err);
    cur_len = cfg.length;
    if (cfg.clear_before) begin
      apb_write(REG_CLEAR, 32'h1, err);
      check({name, " clear pslverr"}, 0, err);
      for (int k = 0; k < MAX_LEN; k++) begin
        model_s[k] = '0;
      end
      pass_count = 0;
      apb_read(REG_PASS_COUNT, d, err);
      check({name, " pass count after clear"}, 0, d);
    end
    prepare_gates(cfg.modulus, int'(cfg.length));
    fork
      drive_inputs(int'(cfg.length));
      collect_outputs(name, int'(cfg.length), int'(cfg.stall_pct), cfg.modulus);
      begin
        if (cfg.busy_write) begin
          write_length_while_busy(name);
        end
      end
    join
    check({name, " no extra beat"}, 0, out_valid);
    for (int k = 0; k < int'(cfg.length); k++) begin
      model_s[k] = exp_s[k];
    end
    pass_count++;
    apb_read(REG_PASS_COUNT, d, err);
    check({name, " pass count"}, pass_count, d);
    apb_read(REG_STATUS, d, err);
    check({name, " status idle"}, 0, d);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    apb_data_t d;
    logic      err;
    RST       = 1'b1;
    apb_req   = '0;
    in_beat   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    pass_count = 0;
    void'($urandom(SEED));
    for (int k = 0; k < MAX_LEN; k++) begin
      model_s[k] = '0;
    end

    // Name, modulus, length, clear, stall %, busy write
    add_pass("first_pass",    16'd65521, 5'd8,  1'b1, 7'd0,  1'b0);
    add_pass("accum_wide",    16'd65521, 5'd8,  1'b0, 7'd25, 1'b0);
    add_pass("mod7_len5_a",   16'd7,     5'd5,  1'b0, 7'd0,  1'b0);
    add_pass("mod7_len5_b",   16'd7,     5'd5,  1'b0, 7'd50, 1'b0);
    add_pass("mod251_len16",  16'd251,   5'd16, 1'b0, 7'd30, 1'b1);
    add_pass("mod251_len1",   16'd251,   5'd1,  1'b0, 7'd0,  1'b0);
    add_pass("cleared_len16", 16'd251,   5'd16, 1'b1, 7'd40, 1'b0);
    add_pass("accum_len16",   16'd251,   5'd16, 1'b0, 7'd70, 1'b0);

    repeat (5) begin
      @(posedge CLK);
    end
    #5;
    RST = 1'b0;

    // Values after reset
    check("reset out_valid", 0, out_valid);
    check("reset in_ready", 1, in_ready);
    apb_read(REG_MODULUS, d, err);
    check("reset MODULUS", MODULUS_RESET, d);
    apb_read(REG_LENGTH, d, err);
    check("reset LENGTH", LENGTH_RESET, d);
    apb_read(REG_STATUS, d, err);
    check("reset STATUS", 0, d);
    apb_read(REG_PASS_COUNT, d, err);
    check("reset PASS_COUNT", 0, d);
    check("reset read pslverr", 0, err);
    cur_mod = elem_t'(MODULUS_RESET);
    cur_len = len_t'(LENGTH_RESET);

    for (int p = 0; p < passes.size(); p++) begin
      run_pass(p);
    end

    // Rejected register accesses
    expect_write_error("LENGTH=0", REG_LENGTH, 32'd0, REG_LENGTH, cur_len);
    expect_write_error("LENGTH=17", REG_LENGTH, 32'd17, REG_LENGTH, cur_len);
    expect_write_error("MODULUS=1", REG_MODULUS, 32'd1, REG_MODULUS, cur_mod);
    expect_write_error("STATUS write", REG_STATUS, 32'd1, REG_STATUS, 0);
    expect_write_error("unmapped write", 8'h20, 32'd5, REG_MODULUS, cur_mod);
    apb_read(8'h20, d, err);
    check("unmapped read pslverr", 1, err);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* lstm_state_gate.f */
hdl/lstm_state_pkg.sv
hdl/lstm_apb_pkg.sv
hdl/lstm_state_regs.sv
hdl/lstm_gate_sequencer.sv
hdl/lstm_state_memory.sv
hdl/lstm_gate_product_stage.sv
hdl/lstm_state_sum_stage.sv
hdl/lstm_state_gate_top.sv
dv/lstm_state_gate_tb.sv

/* Makefile */
TOP := lstm_state_gate_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f lstm_state_gate.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
